/* rtl/rv32m_pkg.sv */
package rv32m_pkg;

  // funct3 codes of the M-extension multiplies (opcode OP, funct7 = 1)
  localparam logic [2:0] funct3_mul    = 3'b000;
  localparam logic [2:0] funct3_mulh   = 3'b001;
  localparam logic [2:0] funct3_mulhsu = 3'b010;
  localparam logic [2:0] funct3_mulhu  = 3'b011;

  // how the two operands are interpreted by the multiplier
  typedef enum logic [1:0] {
    signed_signed     = 2'd0,
    signed_unsigned   = 2'd1,
    unsigned_unsigned = 2'd2
  } mul_kind_e;

  // mul only keeps the low word, so signedness does not matter there
  function automatic mul_kind_e mul_kind_of(input logic [2:0] funct3);
    mul_kind_e kind;
    case (funct3)
      funct3_mul,
      funct3_mulh: begin
        kind = signed_signed;
      end
      funct3_mulhsu: begin
        kind = signed_unsigned;
      end
      funct3_mulhu: begin
        kind = unsigned_unsigned;
      end
      default: begin
        kind = signed_signed;
      end
    endcase
    return kind;
  endfunction

endpackage

/* rtl/ooo_pkg.sv */
package ooo_pkg;

  // sizing of the out-of-order core around the multiply station

  // width of a ROB tag, 8 ROB entries
  localparam int ROB_TAG_W_DEFAULT = 3;

  // number of common data bus lanes snooped by every station
  localparam int CDB_LANES_DEFAULT = 3;

  // log2 of the station depth, 8 entries
  localparam int RS_DEPTH_DEFAULT = 3;

  // all three are only defaults
  // the top level of each unit takes them as parameters
  // and hands them down to its submodules

  // ROB_TAG_W_DEFAULT   -> tags on issue, CDB and result lane
  // CDB_LANES_DEFAULT   -> unpacked lane arrays on the snoop ports
  // RS_DEPTH_DEFAULT    -> entry count and index widths

endpackage

/* rtl/mul_rs_alloc.sv */
`timescale 1ns/10ps

module mul_rs_alloc #(
  parameter int RS_DEPTH = 3
) (
  input  logic                     issue,
  input  logic [2**RS_DEPTH-1:0]   busy,
  input  logic                     rs1_regfile_ready,
  input  logic [31:0]              rs1_regfile_v,
  input  logic                     rs1_rob_ready,
  input  logic [31:0]              rs1_rob_v,
  input  logic                     rs2_regfile_ready,
  input  logic [31:0]              rs2_regfile_v,
  input  logic                     rs2_rob_ready,
  input  logic [31:0]              rs2_rob_v,
  output logic                     full,
  output logic [2**RS_DEPTH-1:0]   alloc_we,
  output logic                     alloc_rs1_ready,
  output logic [31:0]              alloc_rs1_v,
  output logic                     alloc_rs2_ready,
  output logic [31:0]              alloc_rs2_v
);

  localparam int NUM_ENTRIES = 2**RS_DEPTH;

  // regfile wins over the ROB, otherwise the entry waits on the CDB
  function automatic logic [32:0] pick_src(input logic        rf_ready,
                                           input logic [31:0] rf_v,
                                           input logic        rob_ready,
                                           input logic [31:0] rob_v);
    logic [32:0] src;
    if (rf_ready) begin
      src = {1'b1, rf_v};
    end else if (rob_ready) begin
      src = {1'b1, rob_v};
    end else begin
      src = '0;
    end
    return src;
  endfunction

  assign full = &busy;

  assign {alloc_rs1_ready, alloc_rs1_v} =
    pick_src(rs1_regfile_ready, rs1_regfile_v, rs1_rob_ready, rs1_rob_v);
  assign {alloc_rs2_ready, alloc_rs2_v} =
    pick_src(rs2_regfile_ready, rs2_regfile_v, rs2_rob_ready, rs2_rob_v);

  // lowest free entry takes the issue
  always_comb begin
    logic taken;
    taken    = 1'b0;
    alloc_we = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!busy[i] && !taken) begin
        alloc_we[i] = issue && !full;
        taken       = 1'b1;
      end
    end
  end

endmodule

/* rtl/mul_rs_entry.sv */
`timescale 1ns/10ps

module mul_rs_entry #(
  parameter int ROB_TAG_W = 3,
  parameter int CDB_LANES = 3
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 alloc_we,
  input  logic [2:0]           funct3,
  input  logic [ROB_TAG_W-1:0] target_rob,
  input  logic [ROB_TAG_W-1:0] rs1_rob,
  input  logic [ROB_TAG_W-1:0] rs2_rob,
  input  logic                 alloc_rs1_ready,
  input  logic [31:0]          alloc_rs1_v,
  input  logic                 alloc_rs2_ready,
  input  logic [31:0]          alloc_rs2_v,
  input  logic                 cdb_valid [CDB_LANES],
  input  logic [ROB_TAG_W-1:0] cdb_rob   [CDB_LANES],
  input  logic [31:0]          cdb_v     [CDB_LANES],
  input  logic                 release_en,
  output logic                 busy,
  output logic                 ready,
  output logic [2:0]           entry_funct3,
  output logic [ROB_TAG_W-1:0] entry_rob,
  output logic [31:0]          op_a,
  output logic [31:0]          op_b
);

  // index 0 is rs1, index 1 is rs2
  logic                 busy_q;
  logic [1:0]           src_rdy_q;
  logic [31:0]          src_v_q   [2];
  logic [ROB_TAG_W-1:0] src_tag_q [2];
  logic [2:0]           funct3_q;
  logic [ROB_TAG_W-1:0] rob_q;

  logic [1:0]           alloc_rdy;
  logic [31:0]          alloc_v   [2];
  logic [ROB_TAG_W-1:0] issue_tag [2];
  logic [ROB_TAG_W-1:0] look_tag  [2];
  logic [1:0]           cdb_hit;
  logic [31:0]          cdb_hit_v [2];

  assign alloc_rdy    = {alloc_rs2_ready, alloc_rs1_ready};
  assign alloc_v[0]   = alloc_rs1_v;
  assign alloc_v[1]   = alloc_rs2_v;
  assign issue_tag[0] = rs1_rob;
  assign issue_tag[1] = rs2_rob;

  // on the issue cycle the incoming tag is snooped, afterwards the stored one
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      look_tag[k]  = alloc_we ? issue_tag[k] : src_tag_q[k];
      cdb_hit[k]   = 1'b0;
      cdb_hit_v[k] = '0;
      // lane 0 has priority
      for (int j = CDB_LANES - 1; j >= 0; j--) begin
        if (cdb_valid[j] && cdb_rob[j] == look_tag[k]) begin
          cdb_hit[k]   = 1'b1;
          cdb_hit_v[k] = cdb_v[j];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      src_rdy_q <= '0;
    end else if (flush || release_en) begin
      busy_q    <= 1'b0;
      src_rdy_q <= '0;
    end else if (alloc_we) begin
      busy_q    <= 1'b1;
      src_rdy_q <= alloc_rdy | cdb_hit;
    end else if (busy_q) begin
      src_rdy_q <= src_rdy_q | cdb_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_we) begin
      funct3_q <= funct3;
      rob_q    <= target_rob;
    end
    for (int k = 0; k < 2; k++) begin
      if (alloc_we) begin
        src_tag_q[k] <= issue_tag[k];
        src_v_q[k]   <= alloc_rdy[k] ? alloc_v[k] : cdb_hit_v[k];
      end else if (busy_q && !src_rdy_q[k] && cdb_hit[k]) begin
        src_v_q[k] <= cdb_hit_v[k];
      end
    end
  end

  assign busy         = busy_q;
  assign ready        = busy_q && (&src_rdy_q);
  assign entry_funct3 = funct3_q;
  assign entry_rob    = rob_q;
  assign op_a         = src_v_q[0];
  assign op_b         = src_v_q[1];

endmodule

/* rtl/mul_rs_select.sv */
`timescale 1ns/10ps

module mul_rs_select #(
  parameter int ROB_TAG_W = 3,
  parameter int RS_DEPTH  = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic [2**RS_DEPTH-1:0]   ready,
  input  logic [2:0]               entry_funct3 [2**RS_DEPTH],
  input  logic [ROB_TAG_W-1:0]     entry_rob    [2**RS_DEPTH],
  input  logic [31:0]              op_a         [2**RS_DEPTH],
  input  logic [31:0]              op_b         [2**RS_DEPTH],
  input  logic                     mul_done,
  input  logic [63:0]              mul_p,
  output logic [2**RS_DEPTH-1:0]   release_vec,
  output logic                     mul_start,
  output rv32m_pkg::mul_kind_e     mul_kind,
  output logic [31:0]              mul_a,
  output logic [31:0]              mul_b,
  output logic                     result_valid,
  output logic [ROB_TAG_W-1:0]     result_rob,
  output logic [31:0]              result_v
);

  localparam int NUM_ENTRIES = 2**RS_DEPTH;

  logic                 busy_q;
  logic                 start_q;
  logic [RS_DEPTH-1:0]  ptr_q;
  logic [RS_DEPTH-1:0]  idx_q;
  logic [2:0]           funct3_q;
  logic [ROB_TAG_W-1:0] rob_q;
  rv32m_pkg::mul_kind_e kind_q;
  logic [31:0]          a_q;
  logic [31:0]          b_q;

  logic                 found;
  logic [RS_DEPTH-1:0]  pick;

  // round-robin scan starting at the pointer
  always_comb begin
    logic [RS_DEPTH-1:0] cand;
    found = 1'b0;
    pick  = ptr_q;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      cand = ptr_q + (RS_DEPTH)'(i);
      if (!found && ready[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      ptr_q   <= '0;
    end else if (flush) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      ptr_q   <= '0;
    end else begin
      start_q <= 1'b0;
      if (!busy_q && found) begin
        busy_q  <= 1'b1;
        start_q <= 1'b1;
      end
      // next scan begins just past the retired entry
      if (mul_done) begin
        busy_q <= 1'b0;
        ptr_q  <= idx_q + (RS_DEPTH)'(1);
      end
    end
  end

  // launched operation, held until done
  always_ff @(posedge clk) begin
    if (!busy_q && found) begin
      idx_q    <= pick;
      funct3_q <= entry_funct3[pick];
      rob_q    <= entry_rob[pick];
      kind_q   <= rv32m_pkg::mul_kind_of(entry_funct3[pick]);
      a_q      <= op_a[pick];
      b_q      <= op_b[pick];
    end
  end

  always_comb begin
    release_vec = '0;
    if (mul_done) begin
      release_vec[idx_q] = 1'b1;
    end
  end

  assign mul_start = start_q;
  assign mul_kind  = kind_q;
  assign mul_a     = a_q;
  assign mul_b     = b_q;

  // mul keeps the low word, the mulh variants the high word
  assign result_valid = mul_done;
  assign result_rob   = rob_q;
  assign result_v     = (funct3_q == rv32m_pkg::funct3_mul) ? mul_p[31:0] : mul_p[63:32];

endmodule

/* rtl/seq_multiplier32.sv */
`timescale 1ns/10ps

module seq_multiplier32 (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 start,
  input  rv32m_pkg::mul_kind_e kind,
  input  logic [31:0]          a,
  input  logic [31:0]          b,
  output logic [63:0]          p,
  output logic                 done
);

  logic        running_q;
  logic        done_q;
  logic [4:0]  count_q;
  logic [31:0] mcand_q;
  logic [63:0] prod_q;
  logic        neg_q;

  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [32:0] sum;

  // operand signs per kind, b is only signed for signed x signed
  assign a_neg = (kind != rv32m_pkg::unsigned_unsigned) && a[31];
  assign b_neg = (kind == rv32m_pkg::signed_signed) && b[31];
  assign a_mag = a_neg ? (~a + 32'd1) : a;
  assign b_mag = b_neg ? (~b + 32'd1) : b;

  // add the multiplicand into the upper half when the multiplier lsb is set
  assign sum = {1'b0, prod_q[63:32]} + (prod_q[0] ? {1'b0, mcand_q} : 33'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      count_q   <= '0;
    end else if (flush) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      count_q   <= '0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        running_q <= 1'b1;
        count_q   <= '0;
      end else if (running_q) begin
        count_q <= count_q + 5'd1;
        // 32nd iteration
        if (count_q == 5'd31) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mcand_q <= a_mag;
      prod_q  <= {32'd0, b_mag};
      neg_q   <= a_neg ^ b_neg;
    end else if (running_q) begin
      prod_q <= {sum, prod_q[31:1]};
    end
  end

  // sign fix on the magnitude product
  assign p    = neg_q ? (~prod_q + 64'd1) : prod_q;
  assign done = done_q;

endmodule

/* rtl/mul_rs.sv */
`timescale 1ns/10ps

module mul_rs #(
  parameter int ROB_TAG_W = ooo_pkg::ROB_TAG_W_DEFAULT,
  parameter int CDB_LANES = ooo_pkg::CDB_LANES_DEFAULT,
  parameter int RS_DEPTH  = ooo_pkg::RS_DEPTH_DEFAULT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 move_flush,
  input  logic                 issue,
  input  logic [2:0]           issue_funct3,
  input  logic [ROB_TAG_W-1:0] issue_target_rob,
  input  logic                 rs1_regfile_ready,
  input  logic [31:0]          rs1_regfile_v,
  input  logic [ROB_TAG_W-1:0] rs1_regfile_rob,
  input  logic                 rs1_rob_ready,
  input  logic [31:0]          rs1_rob_v,
  input  logic                 rs2_regfile_ready,
  input  logic [31:0]          rs2_regfile_v,
  input  logic [ROB_TAG_W-1:0] rs2_regfile_rob,
  input  logic                 rs2_rob_ready,
  input  logic [31:0]          rs2_rob_v,
  input  logic                 cdb_valid [CDB_LANES],
  input  logic [ROB_TAG_W-1:0] cdb_rob   [CDB_LANES],
  input  logic [31:0]          cdb_v     [CDB_LANES],
  output logic                 full,
  output logic                 result_valid,
  output logic [ROB_TAG_W-1:0] result_rob,
  output logic [31:0]          result_v
);

  localparam int NUM_ENTRIES = 2**RS_DEPTH;

  logic [NUM_ENTRIES-1:0] busy;
  logic [NUM_ENTRIES-1:0] ready;
  logic [NUM_ENTRIES-1:0] alloc_we;
  logic [NUM_ENTRIES-1:0] release_vec;
  logic [2:0]             entry_funct3 [NUM_ENTRIES];
  logic [ROB_TAG_W-1:0]   entry_rob    [NUM_ENTRIES];
  logic [31:0]            op_a         [NUM_ENTRIES];
  logic [31:0]            op_b         [NUM_ENTRIES];
  logic                   alloc_rs1_ready;
  logic [31:0]            alloc_rs1_v;
  logic                   alloc_rs2_ready;
  logic [31:0]            alloc_rs2_v;
  logic                   mul_start;
  rv32m_pkg::mul_kind_e   mul_kind;
  logic [31:0]            mul_a;
  logic [31:0]            mul_b;
  logic [63:0]            mul_p;
  logic                   mul_done;

  mul_rs_alloc #(.RS_DEPTH(RS_DEPTH)) alloc0 (
    .issue(issue), .busy(busy),
    .rs1_regfile_ready(rs1_regfile_ready), .rs1_regfile_v(rs1_regfile_v),
    .rs1_rob_ready(rs1_rob_ready), .rs1_rob_v(rs1_rob_v),
    .rs2_regfile_ready(rs2_regfile_ready), .rs2_regfile_v(rs2_regfile_v),
    .rs2_rob_ready(rs2_rob_ready), .rs2_rob_v(rs2_rob_v),
    .full(full), .alloc_we(alloc_we),
    .alloc_rs1_ready(alloc_rs1_ready), .alloc_rs1_v(alloc_rs1_v),
    .alloc_rs2_ready(alloc_rs2_ready), .alloc_rs2_v(alloc_rs2_v)
  );

  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_entry
    mul_rs_entry #(.ROB_TAG_W(ROB_TAG_W), .CDB_LANES(CDB_LANES)) entry0 (
      .clk(clk), .rst_n(rst_n), .flush(move_flush), .alloc_we(alloc_we[g]),
      .funct3(issue_funct3), .target_rob(issue_target_rob),
      .rs1_rob(rs1_regfile_rob), .rs2_rob(rs2_regfile_rob),
      .alloc_rs1_ready(alloc_rs1_ready), .alloc_rs1_v(alloc_rs1_v),
      .alloc_rs2_ready(alloc_rs2_ready), .alloc_rs2_v(alloc_rs2_v),
      .cdb_valid(cdb_valid), .cdb_rob(cdb_rob), .cdb_v(cdb_v),
      .release_en(release_vec[g]), .busy(busy[g]), .ready(ready[g]),
      .entry_funct3(entry_funct3[g]), .entry_rob(entry_rob[g]),
      .op_a(op_a[g]), .op_b(op_b[g])
    );
  end

  mul_rs_select #(.ROB_TAG_W(ROB_TAG_W), .RS_DEPTH(RS_DEPTH)) select0 (
    .clk(clk), .rst_n(rst_n), .flush(move_flush), .ready(ready),
    .entry_funct3(entry_funct3), .entry_rob(entry_rob), .op_a(op_a), .op_b(op_b),
    .mul_done(mul_done), .mul_p(mul_p), .release_vec(release_vec),
    .mul_start(mul_start), .mul_kind(mul_kind), .mul_a(mul_a), .mul_b(mul_b),
    .result_valid(result_valid), .result_rob(result_rob), .result_v(result_v)
  );

  seq_multiplier32 mult0 (
    .clk(clk), .rst_n(rst_n), .flush(move_flush), .start(mul_start),
    .kind(mul_kind), .a(mul_a), .b(mul_b), .p(mul_p), .done(mul_done)
  );

endmodule

/* verif/tb_mul_rs.sv */
`timescale 1ns/10ps

module tb_mul_rs;

  localparam int  TAG_W       = ooo_pkg::ROB_TAG_W_DEFAULT;
  localparam int  CDB_LANES   = ooo_pkg::CDB_LANES_DEFAULT;
  localparam int  NUM_ENTRIES = 2**ooo_pkg::RS_DEPTH_DEFAULT;
  localparam int  NUM_TAGS    = 2**TAG_W;
  localparam int  CLK_PERIOD  = 100;
  // issued operations over all tests
  localparam int  NUM_OPS     = 63;
  localparam int  WATCHDOG_CYCLES = NUM_OPS * 40 + 500;
  localparam int  RANDOM_OPS  = 24;
  // source modes: regfile, rob, both ready, wait on the cdb
  localparam int  SRC_RF = 0, SRC_ROB = 1, SRC_BOTH = 2, SRC_WAIT = 3;
  localparam int  IDLE = 0, PENDING = 1, DONE = 2;
  localparam time NEVER = '1;
  localparam logic [31:0] CORNER [4] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};

  logic clk, rst_n, move_flush, issue, full, result_valid;
  logic [2:0] issue_funct3;
  logic [TAG_W-1:0] issue_target_rob, rs1_regfile_rob, rs2_regfile_rob, result_rob;
  logic rs1_regfile_ready, rs1_rob_ready, rs2_regfile_ready, rs2_rob_ready;
  logic [31:0] rs1_regfile_v, rs1_rob_v, rs2_regfile_v, rs2_rob_v, result_v;
  logic cdb_valid [CDB_LANES];
  logic [TAG_W-1:0] cdb_rob [CDB_LANES];
  logic [31:0] cdb_v [CDB_LANES];

  // per tag: expected result, completion state, earliest legal arrival
  logic [31:0] exp_v [NUM_TAGS];
  logic [31:0] cdb_tab [NUM_TAGS];
  int state [NUM_TAGS];
  time allow_t [NUM_TAGS];
  int errors = 0;
  int checked = 0;
  logic [31:0] rng;

  mul_rs dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // high word for the mulh variants, low word for mul
  function automatic logic [31:0] model_product(input logic [2:0] f3, input logic [31:0] a,
                                                input logic [31:0] b);
    logic [63:0] ea, eb, p;
    ea = (f3 == rv32m_pkg::funct3_mulhu) ? {32'd0, a} : {{32{a[31]}}, a};
    eb = (f3 == rv32m_pkg::funct3_mulhsu || f3 == rv32m_pkg::funct3_mulhu) ?
         {32'd0, b} : {{32{b[31]}}, b};
    p = ea * eb;
    return (f3 == rv32m_pkg::funct3_mul) ? p[31:0] : p[63:32];
  endfunction

  // {regfile ready, regfile value, rob ready, rob value}, the unused copy is inverted
  function automatic logic [65:0] src_fields(input int m, input logic [31:0] v);
    return {m == SRC_RF || m == SRC_BOTH, (m == SRC_ROB) ? ~v : v,
            m == SRC_ROB || m == SRC_BOTH, (m == SRC_RF || m == SRC_BOTH) ? ~v : v};
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (state[t] == PENDING) n++;
    end
    return n;
  endfunction

  task automatic check_result(input logic [31:0] actual, input logic [TAG_W-1:0] tag);
    checked++;
    if (actual !== exp_v[tag]) begin
      errors++;
      $display("Error: result_v rob %0d expected %h actual %h", tag, exp_v[tag], actual);
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected);
    if (actual !== expected) begin
      errors++;
      $display("Error: full expected %h actual %h", expected, actual);
    end
  endtask

  task automatic clear_cdb();
    for (int l = 0; l < CDB_LANES; l++) begin
      cdb_valid[l] = 1'b0;
      cdb_rob[l]   = '0;
      cdb_v[l]     = '0;
    end
  endtask

  task automatic bcast(input int lane, input int tag);
    cdb_valid[lane] = 1'b1;
    cdb_rob[lane]   = (TAG_W)'(tag);
    cdb_v[lane]     = cdb_tab[tag];
  endtask

  task automatic rand_cdb();
    logic [31:0] r;
    for (int l = 0; l < CDB_LANES; l++) begin
      r = rand32();
      cdb_valid[l] = r[0];
      cdb_rob[l]   = r[TAG_W:1];
      cdb_v[l]     = cdb_tab[r[TAG_W:1]];
    end
  endtask

  // called on a falling edge, returns one cycle later
  task automatic issue_op(input logic [2:0] f3, input int tgt, input int m1,
                          input logic [31:0] v1, input int t1, input int m2,
                          input logic [31:0] v2, input int t2);
    logic [31:0] a, b;
    a = (m1 == SRC_WAIT) ? cdb_tab[t1] : v1;
    b = (m2 == SRC_WAIT) ? cdb_tab[t2] : v2;
    issue            = 1'b1;
    issue_funct3     = f3;
    issue_target_rob = (TAG_W)'(tgt);
    rs1_regfile_rob  = (TAG_W)'(t1);
    rs2_regfile_rob  = (TAG_W)'(t2);
    {rs1_regfile_ready, rs1_regfile_v, rs1_rob_ready, rs1_rob_v} = src_fields(m1, v1);
    {rs2_regfile_ready, rs2_regfile_v, rs2_rob_ready, rs2_rob_v} = src_fields(m2, v2);
    // a full station drops the issue
    if (!full) begin
      exp_v[tgt]   = model_product(f3, a, b);
      state[tgt]   = PENDING;
      allow_t[tgt] = 0;
    end
    @(negedge clk);
    issue = 1'b0;
    {rs1_regfile_ready, rs1_rob_ready, rs2_regfile_ready, rs2_rob_ready} = '0;
  endtask

  task automatic wait_all_done(input bit random_cdb);
    int limit;
    limit = outstanding() * 40 + 100;
    while (outstanding() != 0 && limit > 0) begin
      if (random_cdb) rand_cdb();
      else clear_cdb();
      @(negedge clk);
      limit--;
    end
    clear_cdb();
    if (outstanding() != 0) begin
      errors++;
      $display("%0d results still missing at the end of a test", outstanding());
      for (int t = 0; t < NUM_TAGS; t++) state[t] = IDLE;
    end
    @(negedge clk);
  endtask

  task automatic test_funct3_corners();
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < 4; i++) begin
        issue_op(3'(f), i, SRC_RF, CORNER[i], 0, SRC_RF, CORNER[(i + f) % 4], 0);
      end
      wait_all_done(1'b0);
    end
  endtask

  task automatic test_source_priority();
    issue_op(rv32m_pkg::funct3_mulhu, 0, SRC_ROB, 32'hdead_beef, 0, SRC_ROB, 32'h7, 0);
    issue_op(rv32m_pkg::funct3_mulh, 1, SRC_BOTH, 32'h8765_4321, 0, SRC_BOTH, 32'hffff_fff3, 0);
    wait_all_done(1'b0);
  endtask

  task automatic test_cdb_wakeup();
    issue_op(rv32m_pkg::funct3_mul, 0, SRC_WAIT, 0, 5, SRC_WAIT, 0, 6);
    allow_t[0] = NEVER;
    issue_op(rv32m_pkg::funct3_mulhsu, 1, SRC_WAIT, 0, 7, SRC_RF, rand32(), 0);
    allow_t[1] = NEVER;
    repeat (3) @(negedge clk);
    bcast(0, 5);
    @(negedge clk);
    clear_cdb();
    // longer than the issue to result latency
    repeat (40) @(negedge clk);
    bcast(1, 6);
    bcast(2, 7);
    allow_t[0] = $time;
    allow_t[1] = $time;
    @(negedge clk);
    clear_cdb();
    // rs1 producer broadcasts in the issue cycle itself
    bcast(2, 4);
    issue_op(rv32m_pkg::funct3_mulh, 2, SRC_WAIT, 0, 4, SRC_WAIT, 0, 3);
    allow_t[2] = NEVER;
    clear_cdb();
    repeat (40) @(negedge clk);
    bcast(1, 3);
    allow_t[2] = $time;
    @(negedge clk);
    wait_all_done(1'b0);
  endtask

  task automatic test_full();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      check_flag(full, 1'b0);
      issue_op(rv32m_pkg::funct3_mulhu, i, SRC_WAIT, 0, i, SRC_ROB, rand32(), 0);
    end
    check_flag(full, 1'b1);
    issue_op(rv32m_pkg::funct3_mul, 0, SRC_RF, 32'h1234_5678, 0, SRC_RF, 32'h9abc_def0, 0);
    repeat (40) @(negedge clk);
    check_flag(full, 1'b1);
    for (int i = 0; i < NUM_ENTRIES; i += CDB_LANES) begin
      for (int l = 0; l < CDB_LANES && i + l < NUM_ENTRIES; l++) bcast(l, i + l);
      @(negedge clk);
      clear_cdb();
    end
    wait_all_done(1'b0);
    check_flag(full, 1'b0);
  endtask

  task automatic test_flush();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      issue_op(rv32m_pkg::funct3_mulh, i, SRC_RF, rand32(), 0, SRC_RF, rand32(), 0);
    end
    check_flag(full, 1'b1);
    repeat (5) @(negedge clk);
    move_flush = 1'b1;
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (state[t] == PENDING) state[t] = IDLE;
    end
    @(negedge clk);
    move_flush = 1'b0;
    repeat (40) @(negedge clk);
    check_flag(full, 1'b0);
    issue_op(rv32m_pkg::funct3_mul, 3, SRC_RF, rand32(), 0, SRC_ROB, rand32(), 0);
    wait_all_done(1'b0);
  endtask

  task automatic test_random();
    logic [31:0] r;
    int n;
    int tgt;
    n = 0;
    while (n < RANDOM_OPS) begin
      rand_cdb();
      r   = rand32();
      tgt = int'(r[TAG_W-1:0]);
      if (state[tgt] != PENDING && !full) begin
        issue_op({1'b0, r[13:12]}, tgt, int'(r[15:14]), rand32(), int'(r[2*TAG_W-1:TAG_W]),
                 int'(r[17:16]), rand32(), int'(r[3*TAG_W-1:2*TAG_W]));
        n++;
      end else begin
        @(negedge clk);
      end
    end
    wait_all_done(1'b1);
  endtask

  // results are matched by tag, any completion order is fine
  initial begin
    forever begin
      @(negedge clk);
      if (result_valid === 1'b1) begin
        if (state[result_rob] == PENDING) begin
          if ($time < allow_t[result_rob]) begin
            errors++;
            $display("result for rob %0d arrived before its last operand was broadcast",
                     result_rob);
          end
          check_result(result_v, result_rob);
          state[result_rob] = DONE;
        end else if (state[result_rob] == DONE) begin
          errors++;
          $display("duplicate result for rob %0d", result_rob);
        end else begin
          errors++;
          $display("result for rob %0d with no operation outstanding", result_rob);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    rng = 32'h32c6_92b1;
    rst_n = 1'b0;
    move_flush = 1'b0;
    issue = 1'b0;
    issue_funct3 = '0;
    issue_target_rob = '0;
    rs1_regfile_rob = '0;
    rs2_regfile_rob = '0;
    {rs1_regfile_ready, rs1_regfile_v, rs1_rob_ready, rs1_rob_v} = '0;
    {rs2_regfile_ready, rs2_regfile_v, rs2_rob_ready, rs2_rob_v} = '0;
    clear_cdb();
    for (int t = 0; t < NUM_TAGS; t++) begin
      state[t]   = IDLE;
      allow_t[t] = 0;
      exp_v[t]   = '0;
      cdb_tab[t] = rand32();
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag(full, 1'b0);
    test_funct3_corners();
    test_source_priority();
    test_cdb_wakeup();
    test_full();
    test_flush();
    test_random();
    $display("errors %0d, results checked %0d", errors, checked);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
rtl/rv32m_pkg.sv
rtl/ooo_pkg.sv
rtl/mul_rs_alloc.sv
rtl/mul_rs_entry.sv
rtl/mul_rs_select.sv
rtl/seq_multiplier32.sv
rtl/mul_rs.sv
verif/tb_mul_rs.sv

/* run.sh */
#!/bin/sh
# build and run the multiply reservation station testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_mul_rs -f tb.f -o sim_tb_mul_rs

./obj_dir/sim_tb_mul_rs > sim.log 2>&1
cat sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
